// ==== logic/bnn_fc_consts.svh ====
`ifndef BNN_FC_CONSTS_SVH
`define BNN_FC_CONSTS_SVH

// bits per beat
`define BNN_LANES 12

// beats per frame
`define BNN_BEATS 12

// lanes times beats
`define BNN_WEIGHTS 144

// sampled beat to accumulator update
`define BNN_PIPE_LAT 6

`endif

// ==== logic/bnn_fc_pkg.sv ====
`include "bnn_fc_consts.svh"

package bnn_fc_pkg;

    // input word, weight row or xnor match
    typedef logic [`BNN_LANES-1:0] lane_vec_t;

    // beat number within a frame
    typedef logic [3:0] beat_idx_t;

    // serial weight load address
    typedef logic [7:0] waddr_t;

    // pair, group or beat score, -12 .. 12
    typedef logic signed [7:0] beat_score_t;

    // frame sum, -144 .. 144
    typedef logic signed [15:0] acc_t;

endpackage

// ==== logic/weight_store.sv ====
`timescale 1ns/100ps
`include "bnn_fc_consts.svh"

module weight_store (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  weight,
    input  logic                  weight_en,
    input  logic                  ivalid,
    input  bnn_fc_pkg::beat_idx_t beat_idx,
    output bnn_fc_pkg::lane_vec_t row
);

    import bnn_fc_pkg::*;

    waddr_t                  waddr;
    logic [`BNN_WEIGHTS-1:0] w_bits;
    logic                    addr_last;

    assign addr_last = (waddr == waddr_t'(`BNN_WEIGHTS - 1));

    // load address, one step per loaded bit
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            waddr <= '0;
        end else if (weight_en) begin
            if (addr_last) begin
                waddr <= '0;
            end else begin
                waddr <= waddr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (weight_en) begin
            w_bits[waddr] <= weight;
        end
    end

    // row r is weights r*12 .. r*12+11, lane 0 at the low end
    assign row = w_bits[beat_idx * `BNN_LANES +: `BNN_LANES];

    // rows are read straight from the load register
    a_no_load_with_beat: assert property (
        @(posedge clk) disable iff (!rstn)
        !(weight_en && ivalid)
    ) else $error("weight_en and ivalid high in the same cycle");

endmodule

// ==== logic/xnor_match.sv ====
`timescale 1ns/100ps
`include "bnn_fc_consts.svh"

module xnor_match (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ivalid,
    input  bnn_fc_pkg::lane_vec_t din,
    input  bnn_fc_pkg::lane_vec_t row,
    output bnn_fc_pkg::beat_idx_t beat_idx,
    output bnn_fc_pkg::lane_vec_t match,
    output logic                  match_valid,
    output logic                  match_last
);

    import bnn_fc_pkg::*;

    logic last_beat;

    assign last_beat = (beat_idx == beat_idx_t'(`BNN_BEATS - 1));

    // frame beat counter, holds through ivalid gaps
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_idx    <= '0;
            match_valid <= 1'b0;
            match_last  <= 1'b0;
        end else begin
            match_valid <= ivalid;
            match_last  <= ivalid && last_beat;
            if (ivalid) begin
                if (last_beat) begin
                    beat_idx <= '0;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                end
            end
        end
    end

    // 1 where input bit and weight agree
    always_ff @(posedge clk) begin
        if (ivalid) begin
            match <= din ~^ row;
        end
    end

    a_beat_in_range: assert property (
        @(posedge clk) disable iff (!rstn)
        beat_idx <= beat_idx_t'(`BNN_BEATS - 1)
    ) else $error("beat_idx out of range: %0d", beat_idx);

endmodule

// ==== logic/popcount_tree.sv ====
`timescale 1ns/100ps
`include "bnn_fc_consts.svh"

module popcount_tree (
    input  logic                    clk,
    input  logic                    rstn,
    input  bnn_fc_pkg::lane_vec_t   match,
    input  logic                    match_valid,
    input  logic                    match_last,
    output bnn_fc_pkg::beat_score_t score,
    output logic                    score_valid,
    output logic                    score_last
);

    import bnn_fc_pkg::*;

    beat_score_t pair_q [`BNN_LANES/2];
    beat_score_t sum_q [3];
    beat_score_t group_q [2];

    // [0] pair stage, [1] sum stage, [2] group stage
    logic [2:0] vld_q;
    logic [2:0] lst_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_q       <= '0;
            lst_q       <= '0;
            score_valid <= 1'b0;
            score_last  <= 1'b0;
        end else begin
            vld_q       <= {vld_q[1:0], match_valid};
            lst_q       <= {lst_q[1:0], match_last};
            score_valid <= vld_q[2];
            score_last  <= lst_q[2];
        end
    end

    // both match +2, both differ -2, else 0
    always_ff @(posedge clk) begin
        for (int p = 0; p < `BNN_LANES/2; p++) begin
            if (!match_valid) begin
                pair_q[p] <= '0;
            end else if (match[2*p] && match[2*p+1]) begin
                pair_q[p] <= 8'sd2;
            end else if (!match[2*p] && !match[2*p+1]) begin
                pair_q[p] <= -8'sd2;
            end else begin
                pair_q[p] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (vld_q[0]) begin
            sum_q[0] <= pair_q[0] + pair_q[1];
            sum_q[1] <= pair_q[2] + pair_q[3];
            sum_q[2] <= pair_q[4] + pair_q[5];
        end else begin
            sum_q[0] <= '0;
            sum_q[1] <= '0;
            sum_q[2] <= '0;
        end
    end

    // third sum just rides along one stage
    always_ff @(posedge clk) begin
        if (vld_q[1]) begin
            group_q[0] <= sum_q[0] + sum_q[1];
            group_q[1] <= sum_q[2];
        end else begin
            group_q[0] <= '0;
            group_q[1] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (vld_q[2]) begin
            score <= group_q[0] + group_q[1];
        end else begin
            score <= '0;
        end
    end

    a_score_range: assert property (
        @(posedge clk) disable iff (!rstn)
        score_valid |-> (score >= -(`BNN_LANES) && score <= `BNN_LANES)
    ) else $error("beat score out of range: %0d", score);

endmodule

// ==== logic/frame_accum.sv ====
`timescale 1ns/100ps

module frame_accum (
    input  logic                    clk,
    input  logic                    rstn,
    input  bnn_fc_pkg::beat_score_t score,
    input  logic                    score_valid,
    input  logic                    score_last,
    output bnn_fc_pkg::acc_t        dout,
    output logic                    ovalid
);

    import bnn_fc_pkg::*;

    // set after the first beat of a frame lands
    logic frame_open;
    acc_t score_ext;

    assign score_ext = acc_t'(score);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            frame_open <= 1'b0;
        end else if (score_valid) begin
            frame_open <= !score_last;
        end
    end

    // first beat loads, the rest add
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dout <= '0;
        end else if (score_valid) begin
            if (frame_open) begin
                dout <= dout + score_ext;
            end else begin
                dout <= score_ext;
            end
        end
    end

    // one-cycle pulse with the completed sum
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ovalid <= 1'b0;
        end else begin
            ovalid <= score_valid && score_last;
        end
    end

endmodule

// ==== logic/bnn_fc.sv ====
`timescale 1ns/100ps

module bnn_fc (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  ivalid,
    input  bnn_fc_pkg::lane_vec_t din,
    input  logic                  weight,
    input  logic                  weight_en,
    output logic                  ovalid,
    output bnn_fc_pkg::acc_t      dout
);

    import bnn_fc_pkg::*;

    beat_idx_t   beat_idx;
    lane_vec_t   row;
    lane_vec_t   match;
    logic        match_valid;
    logic        match_last;
    beat_score_t score;
    logic        score_valid;
    logic        score_last;

    weight_store u_weight_store (
        .clk       (clk),
        .rstn      (rstn),
        .weight    (weight),
        .weight_en (weight_en),
        .ivalid    (ivalid),
        .beat_idx  (beat_idx),
        .row       (row)
    );

    xnor_match u_xnor_match (
        .clk         (clk),
        .rstn        (rstn),
        .ivalid      (ivalid),
        .din         (din),
        .row         (row),
        .beat_idx    (beat_idx),
        .match       (match),
        .match_valid (match_valid),
        .match_last  (match_last)
    );

    popcount_tree u_popcount_tree (
        .clk         (clk),
        .rstn        (rstn),
        .match       (match),
        .match_valid (match_valid),
        .match_last  (match_last),
        .score       (score),
        .score_valid (score_valid),
        .score_last  (score_last)
    );

    frame_accum u_frame_accum (
        .clk         (clk),
        .rstn        (rstn),
        .score       (score),
        .score_valid (score_valid),
        .score_last  (score_last),
        .dout        (dout),
        .ovalid      (ovalid)
    );

endmodule

// ==== test/tb_bnn_fc_tasks.svh ====
`ifndef TB_BNN_FC_TASKS_SVH
`define TB_BNN_FC_TASKS_SVH

task automatic check_acc(input string name, input acc_t exp, input acc_t act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        err_count++;
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[ERROR] %s expected %b actual %b", name, exp, act);
        err_count++;
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
        err_count++;
    end
endtask

task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: %0d check(s) failed", name, err_count - errs_before);
    end
endtask

// shifts model_w in, address 0 first
task automatic load_weights();
    for (int k = 0; k < `BNN_WEIGHTS; k++) begin
        @(posedge clk);
        weight_en <= 1'b1;
        weight    <= model_w[k];
    end
    @(posedge clk);
    weight_en <= 1'b0;
endtask

// 0..3 idle cycles before each beat when gapped
task automatic send_frame(input int slot, input logic gapped);
    int gap;
    for (int b = 0; b < `BNN_BEATS; b++) begin
        gap = 0;
        if (gapped) begin
            gap = take_bit();
            gap = gap * 2 + take_bit();
        end
        repeat (gap) begin
            @(posedge clk);
            ivalid <= 1'b0;
        end
        @(posedge clk);
        ivalid <= 1'b1;
        din    <= frame_mem[slot][b];
        @(negedge clk);
        last_beat_edge = edge_cnt;
    end
endtask

task automatic end_beats();
    @(posedge clk);
    ivalid <= 1'b0;
    din    <= '0;
endtask

task automatic wait_ovalid(output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < 100) begin
        @(negedge clk);
        seen = ovalid;
        n++;
    end
    if (!seen) begin
        $display("timeout: no ovalid pulse within 100 cycles");
        err_count++;
    end
endtask

// result value, then the pulse must be gone one cycle later
task automatic collect_result(input string name, input acc_t exp, output int lat);
    logic seen;
    lat = 0;
    wait_ovalid(seen);
    if (seen) begin
        lat = edge_cnt - last_beat_edge;
        check_acc(name, exp, dout);
        @(negedge clk);
        check_bit({name, " pulse width"}, 1'b0, ovalid);
    end
endtask

`endif

// ==== test/tb_bnn_fc.sv ====
`timescale 1ns/100ps
`include "bnn_fc_consts.svh"

module tb_bnn_fc;

    import bnn_fc_pkg::*;

    logic        clk;
    logic        rstn;
    logic        ivalid;
    lane_vec_t   din;
    logic        weight;
    logic        weight_en;
    logic        ovalid;
    acc_t        dout;

    logic [15:0] lfsr_q;
    logic        model_w [`BNN_WEIGHTS];
    lane_vec_t   frame_mem [4][`BNN_BEATS];
    acc_t        exp_sum [3];
    int          edge_cnt;
    int          last_beat_edge;
    int          err_count;
    int          tests_run;
    int          tests_failed;

    bnn_fc DUT (
        .clk       (clk),
        .rstn      (rstn),
        .ivalid    (ivalid),
        .din       (din),
        .weight    (weight),
        .weight_en (weight_en),
        .ovalid    (ovalid),
        .dout      (dout)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_step(lfsr_q);
        return lfsr_q[0];
    endfunction

    function automatic lane_vec_t rand_word();
        lane_vec_t w;
        for (int i = 0; i < `BNN_LANES; i++) begin
            w[i] = take_bit();
        end
        return w;
    endfunction

    // +1 per agreeing lane, -1 per differing lane
    function automatic acc_t frame_sum(input int slot);
        acc_t s;
        s = '0;
        for (int b = 0; b < `BNN_BEATS; b++) begin
            for (int l = 0; l < `BNN_LANES; l++) begin
                if (frame_mem[slot][b][l] == model_w[b * `BNN_LANES + l]) begin
                    s = s + 1;
                end else begin
                    s = s - 1;
                end
            end
        end
        return s;
    endfunction

    `include "tb_bnn_fc_tasks.svh"

    initial begin
        int errs;
        int lat;
        clk = 1'b0;
        rstn = 1'b0;
        ivalid = 1'b0;
        din = '0;
        weight = 1'b0;
        weight_en = 1'b0;
        lfsr_q = 16'd18950;
        edge_cnt = 0;
        last_beat_edge = 0;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        rstn <= 1'b1;

        errs = err_count;
        @(negedge clk);
        check_bit("reset ovalid", 1'b0, ovalid);
        check_acc("reset dout", '0, dout);
        finish_test("reset values", errs);

        errs = err_count;
        for (int k = 0; k < `BNN_WEIGHTS; k++) begin
            model_w[k] = 1'b1;
        end
        load_weights();
        for (int b = 0; b < `BNN_BEATS; b++) begin
            frame_mem[3][b] = '1;
        end
        send_frame(3, 1'b0);
        end_beats();
        collect_result("all ones", 16'sd144, lat);
        check_count("all ones latency", `BNN_PIPE_LAT, lat);
        for (int b = 0; b < `BNN_BEATS; b++) begin
            frame_mem[3][b] = '0;
        end
        send_frame(3, 1'b0);
        end_beats();
        collect_result("all zeros", -16'sd144, lat);
        finish_test("extreme frames", errs);

        errs = err_count;
        for (int k = 0; k < `BNN_WEIGHTS; k++) begin
            model_w[k] = take_bit();
        end
        load_weights();
        for (int f = 0; f < 3; f++) begin
            for (int b = 0; b < `BNN_BEATS; b++) begin
                frame_mem[f][b] = rand_word();
            end
            exp_sum[f] = frame_sum(f);
        end
        // results come out while later frames are still going in
        fork
            begin
                for (int f = 0; f < 3; f++) begin
                    send_frame(f, 1'b0);
                end
                end_beats();
            end
            begin
                for (int f = 0; f < 3; f++) begin
                    collect_result($sformatf("frame %0d", f), exp_sum[f], lat);
                end
            end
        join
        finish_test("back to back frames", errs);

        errs = err_count;
        for (int b = 0; b < `BNN_BEATS; b++) begin
            frame_mem[3][b] = rand_word();
        end
        send_frame(3, 1'b0);
        end_beats();
        collect_result("no gaps", frame_sum(3), lat);
        send_frame(3, 1'b1);
        end_beats();
        collect_result("with gaps", frame_sum(3), lat);
        finish_test("gapped frame", errs);

        errs = err_count;
        for (int k = 0; k < `BNN_WEIGHTS; k++) begin
            model_w[k] = take_bit();
        end
        load_weights();
        send_frame(0, 1'b0);
        end_beats();
        collect_result("reloaded weights", frame_sum(0), lat);
        finish_test("weight reload", errs);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== bnn_fc.f ====
+incdir+logic
+incdir+test
logic/bnn_fc_pkg.sv
logic/weight_store.sv
logic/xnor_match.sv
logic/popcount_tree.sv
logic/frame_accum.sv
logic/bnn_fc.sv
test/tb_bnn_fc.sv
